//--- verilog/or1k_fpu_op_pkg.sv
// decoded FPU operation only; the generic compare code is the low 3 bits of the OR1K lf.sf* opcode
package or1k_fpu_op_pkg;

  ////////////////////////////////////////
  // compare opcode field
  ////////////////////////////////////////

  localparam int GENERIC_CMP_W = 3;  // low bits of lf.sf* opcode

  // relation selected by a compare, same code for ordered and unordered forms
  typedef enum logic [GENERIC_CMP_W-1:0] {
    SFEQ = 3'd0,  // a == b
    SFNE = 3'd1,  // a != b
    SFGT = 3'd2,  // a >  b
    SFGE = 3'd3,  // a >= b
    SFLT = 3'd4,  // a <  b
    SFLE = 3'd5   // a <= b
  } fpu_generic_cmp_e;

  ////////////////////////////////////////
  // decoded operation, 6 bits
  ////////////////////////////////////////

  // is_comp and is_sub are never set together
  typedef struct packed {
    logic             is_comp;      // lf.sf* family
    logic             unordered;    // lf.sfu* variant, NaN makes the flag true
    fpu_generic_cmp_e generic_cmp;  // relation, only meaningful with is_comp
    logic             is_sub;       // lf.sub.s, else lf.add.s
  } fpu_op_t;

endpackage

//--- verilog/pfpu32_num_pkg.sv
// single precision only; exponents stay biased, denormals are flushed before they reach these types
package pfpu32_num_pkg;

  ////////////////////////////////////////
  // format constants
  ////////////////////////////////////////

  localparam int EXP_BIAS = 127;

  // all-ones 8 bit exponent field, inf and NaN
  localparam logic [7:0] EXP_MAX = 8'(2 * EXP_BIAS + 1);

  // same code widened to the 10 bit internal exponent
  localparam logic [9:0] INF_EXP = {2'b00, EXP_MAX};

  // default NaN returned for every NaN producing add/sub
  localparam logic [31:0] QNAN_CANON = 32'h7FC0_0000;

  ////////////////////////////////////////
  // unpacked operand
  ////////////////////////////////////////

  typedef struct packed {
    logic        sign;
    logic [9:0]  exp10;    // biased, 0 for zero
    logic [23:0] fract24;  // hidden bit at [23]
    logic        snan;     // signalling NaN
    logic        qnan;     // quiet NaN
    logic        inf;
    logic        zero;     // also flushed denormal
  } fp_operand_t;

  ////////////////////////////////////////
  // results
  ////////////////////////////////////////

  typedef struct packed {
    logic cmp_flag;  // relation holds
    logic inv;       // invalid operation
    logic inf;       // an operand was infinite
  } fp_cmp_res_t;

  typedef struct packed {
    logic [31:0] word;     // IEEE 754 single word
    logic        inv;      // inf - inf or sNaN operand
    logic        ovf;      // saturated to inf
    logic        inexact;  // rounding lost bits
  } fp_arith_res_t;

endpackage

//--- verilog/pfpu32_unpack.sv
// purely combinational; a denormal word is reported as a zero of the same sign, no exceptions raised
`timescale 1ns/100ps

module pfpu32_unpack
  import pfpu32_num_pkg::*;
(
  input  logic [31:0] word_i,
  output fp_operand_t opnd_o
);

  ////////////////////////////////////////
  // field split
  ////////////////////////////////////////

  logic        sign;
  logic [7:0]  exp8;
  logic [22:0] fract23;
  logic        exp_zero;   // zero or denormal
  logic        exp_ones;   // inf or NaN
  logic        fract_nz;

  assign sign     = word_i[31];
  assign exp8     = word_i[30:23];
  assign fract23  = word_i[22:0];

  assign exp_zero = (exp8 == 8'd0);
  assign exp_ones = (exp8 == EXP_MAX);
  assign fract_nz = |fract23;

  ////////////////////////////////////////
  // classification
  ////////////////////////////////////////

  always_comb begin
    opnd_o.sign = sign;  // kept for zeros too

    // flush to zero, exponent and fraction both cleared
    if (exp_zero) begin
      opnd_o.exp10   = 10'd0;
      opnd_o.fract24 = 24'd0;
    end else begin
      opnd_o.exp10   = {2'b00, exp8};
      opnd_o.fract24 = {1'b1, fract23};  // hidden bit
    end

    // quiet bit is the fraction msb
    opnd_o.qnan = exp_ones & fract23[22];
    opnd_o.snan = exp_ones & ~fract23[22] & fract_nz;
    opnd_o.inf  = exp_ones & ~fract_nz;
    opnd_o.zero = exp_zero;  // denormals land here
  end

endmodule

//--- verilog/pfpu32_fcmp.sv
// combinational compare; clk only samples the assertion, results are latched by the FPU top level
`timescale 1ns/100ps

module pfpu32_fcmp
  import or1k_fpu_op_pkg::*;
  import pfpu32_num_pkg::*;
(
  input  logic        clk,               // assertion sampling only
  input  logic        fpu_op_is_comp_i,
  input  fpu_op_t     op_i,
  input  fp_operand_t opa_i,
  input  fp_operand_t opb_i,
  // magnitude order for the adder
  output logic        addsub_agtb_o,
  output logic        addsub_aeqb_o,
  // outputs
  output fp_cmp_res_t res_o,
  output logic        ready_o
);

  ////////////////////////////////////////
  // exception analysis
  ////////////////////////////////////////

  logic qnan;
  logic snan;
  logic anan;
  logic eqne;
  logic inv_cmp;

  assign qnan = opa_i.qnan | opb_i.qnan;
  assign snan = opa_i.snan | opb_i.snan;
  assign anan = qnan | snan;

  assign eqne = (op_i.generic_cmp == SFEQ) | (op_i.generic_cmp == SFNE);

  // sNaN in EQ/NE of either form, or any NaN in ordered GT/GE/LT/LE
  assign inv_cmp = (eqne & snan) | (~eqne & anan & ~op_i.unordered);

  ////////////////////////////////////////
  // magnitude relations
  ////////////////////////////////////////

  logic exp_gt, exp_eq;
  logic fract_gt, fract_eq;
  logic mag_gt, mag_eq;
  logic all_zero;

  assign exp_gt   = opa_i.exp10 > opb_i.exp10;
  assign exp_eq   = opa_i.exp10 == opb_i.exp10;
  assign fract_gt = opa_i.fract24 > opb_i.fract24;
  assign fract_eq = opa_i.fract24 == opb_i.fract24;

  assign mag_gt   = exp_gt | (exp_eq & fract_gt);  // |a| > |b|
  assign mag_eq   = exp_eq & fract_eq;
  assign all_zero = opa_i.zero & opb_i.zero;       // +0 == -0

  ////////////////////////////////////////
  // signed relation, priority order
  ////////////////////////////////////////

  logic altb, blta, aeqb;

  always_comb begin
    altb = 1'b0;
    blta = 1'b0;
    aeqb = 1'b0;
    if (anan) begin
      // unordered, no relation holds
    end else if (opa_i.inf & opb_i.inf) begin
      if (opa_i.sign == opb_i.sign) aeqb = 1'b1;  // same inf
      else if (opa_i.sign)          altb = 1'b1;  // -inf < +inf
      else                          blta = 1'b1;
    end else if (opa_i.inf) begin
      if (opa_i.sign) altb = 1'b1;
      else            blta = 1'b1;
    end else if (opb_i.inf) begin
      if (opb_i.sign) blta = 1'b1;
      else            altb = 1'b1;
    end else if (all_zero) begin
      aeqb = 1'b1;
    end else if (opa_i.sign != opb_i.sign) begin
      if (opa_i.sign) altb = 1'b1;  // negative side is smaller
      else            blta = 1'b1;
    end else if (mag_eq) begin
      aeqb = 1'b1;
    end else if (mag_gt ^ opa_i.sign) begin
      blta = 1'b1;  // larger positive, or smaller negative
    end else begin
      altb = 1'b1;
    end
  end

  ////////////////////////////////////////
  // flag select
  ////////////////////////////////////////

  logic generic_cmp_flag;

  always_comb begin
    case (op_i.generic_cmp)
      SFEQ:    generic_cmp_flag = aeqb;
      SFNE:    generic_cmp_flag = ~aeqb;
      SFGT:    generic_cmp_flag = blta & ~aeqb;
      SFGE:    generic_cmp_flag = blta | aeqb;
      SFLT:    generic_cmp_flag = altb & ~aeqb;
      SFLE:    generic_cmp_flag = altb | aeqb;
      default: generic_cmp_flag = 1'b0;  // reserved codes
    endcase
  end

  // unordered form is true whenever a NaN is present
  assign res_o.cmp_flag = (op_i.unordered & anan) | generic_cmp_flag;
  assign res_o.inv      = inv_cmp;
  assign res_o.inf      = opa_i.inf | opb_i.inf;
  assign ready_o        = fpu_op_is_comp_i;

  // adder support ignores signs
  assign addsub_agtb_o = mag_gt;
  assign addsub_aeqb_o = mag_eq;

  // zero operands arrive with cleared fields, mag_gt and mag_eq count on that
  a_zero_flushed : assert property (@(posedge clk)
      (!opa_i.zero || (opa_i.exp10 == 10'd0 && opa_i.fract24 == 24'd0)) &&
      (!opb_i.zero || (opb_i.exp10 == 10'd0 && opb_i.fract24 == 24'd0)))
    else $error("fcmp zero operand with nonzero fields");

endmodule

//--- verilog/pfpu32_addsub.sv
// round to nearest even only; denormal results flush to zero and every NaN result is the canonical qNaN
`timescale 1ns/100ps

module pfpu32_addsub
  import or1k_fpu_op_pkg::*;
  import pfpu32_num_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n_i,
  input  logic          start_i,
  input  fpu_op_t       op_i,
  input  fp_operand_t   opa_i,
  input  fp_operand_t   opb_i,
  input  logic          agtb_i,   // |a| > |b| from fcmp
  input  logic          aeqb_i,   // |a| == |b| from fcmp
  output fp_arith_res_t res_o,
  output logic          ready_o
);

  ////////////////////////////////////////
  // stage 1 order and align
  ////////////////////////////////////////

  logic        signb_eff;  // b sign after lf.sub
  logic        sub_eff;    // magnitudes get subtracted
  logic        a_first;
  fp_operand_t opl;        // larger magnitude
  fp_operand_t ops;        // smaller magnitude
  logic        sign_l;
  logic [9:0]  exp_diff;
  logic [4:0]  shift;
  logic [49:0] wide;
  logic [26:0] fract_l_ext;  // {fract24, g, r, s}
  logic [26:0] fract_s_ext;
  logic [27:0] sum;          // carry at [27]

  assign signb_eff = opb_i.sign ^ op_i.is_sub;
  assign sub_eff   = opa_i.sign ^ signb_eff;
  assign a_first   = agtb_i | aeqb_i;

  assign opl    = a_first ? opa_i : opb_i;
  assign ops    = a_first ? opb_i : opa_i;
  assign sign_l = a_first ? opa_i.sign : signb_eff;

  assign exp_diff = opl.exp10 - ops.exp10;  // never negative
  assign shift    = (exp_diff > 10'd26) ? 5'd26 : exp_diff[4:0];  // 26 clears all

  // shifted-out bits collapse into sticky
  assign wide        = {ops.fract24, 26'd0} >> shift;
  assign fract_l_ext = {opl.fract24, 3'b000};
  assign fract_s_ext = {wide[49:24], |wide[23:0]};

  assign sum = sub_eff ? ({1'b0, fract_l_ext} - {1'b0, fract_s_ext})
                       : ({1'b0, fract_l_ext} + {1'b0, fract_s_ext});

  ////////////////////////////////////////
  // stage 1 special cases
  ////////////////////////////////////////

  logic        any_snan;
  logic        any_nan;
  logic        inf_inf_sub;  // inf - inf
  logic        spec;
  logic [31:0] spec_word;

  assign any_snan    = opa_i.snan | opb_i.snan;
  assign any_nan     = any_snan | opa_i.qnan | opb_i.qnan;
  assign inf_inf_sub = opa_i.inf & opb_i.inf & sub_eff;
  assign spec        = any_nan | opa_i.inf | opb_i.inf;

  always_comb begin
    if (any_nan | inf_inf_sub) begin
      spec_word = QNAN_CANON;
    end else if (opa_i.inf) begin
      spec_word = {opa_i.sign, INF_EXP[7:0], 23'd0};  // inf passes through
    end else begin
      spec_word = {signb_eff, INF_EXP[7:0], 23'd0};
    end
  end

  ////////////////////////////////////////
  // stage 1 register
  ////////////////////////////////////////

  logic        s1_valid;
  logic        s1_spec;
  logic [31:0] s1_spec_word;
  logic        s1_inv;
  logic        s1_sign;
  logic [9:0]  s1_exp;
  logic [27:0] s1_sum;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= start_i;
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      s1_spec      <= spec;
      s1_spec_word <= spec_word;
      s1_inv       <= any_snan | inf_inf_sub;
      s1_sign      <= (sub_eff & aeqb_i) ? 1'b0 : sign_l;  // exact cancel gives +0
      s1_exp       <= opl.exp10;
      s1_sum       <= sum;
    end
  end

  ////////////////////////////////////////
  // stage 2 normalize and round
  ////////////////////////////////////////

  // leading zeros of a 27 bit field, 27 when empty
  function automatic logic [4:0] lzc27(input logic [26:0] v);
    logic [4:0] n;
    n = 5'd27;
    for (int i = 0; i < 27; i++) begin
      if (v[i]) n = 5'(26 - i);  // highest set bit wins
    end
    return n;
  endfunction

  logic        carry;
  logic [4:0]  lz;
  logic [26:0] norm;
  logic [23:0] mant;
  logic        rnd_bit;
  logic        sticky;
  logic        round_up;
  logic [24:0] mant_r;
  logic [10:0] exp_n;
  logic [10:0] exp_r;
  logic [22:0] frac23;
  logic        sum_zero;
  logic        underflow;
  logic        overflow;

  assign carry = s1_sum[27];
  assign lz    = lzc27(s1_sum[26:0]);
  assign norm  = s1_sum[26:0] << lz;

  // right shift by one on carry, else left by lz
  assign mant    = carry ? s1_sum[27:4]   : norm[26:3];
  assign rnd_bit = carry ? s1_sum[3]      : norm[2];
  assign sticky  = carry ? |s1_sum[2:0]   : |norm[1:0];
  assign exp_n   = carry ? ({1'b0, s1_exp} + 11'd1) : ({1'b0, s1_exp} - {6'd0, lz});

  assign round_up = rnd_bit & (sticky | mant[0]);  // ties to even
  assign mant_r   = {1'b0, mant} + {24'd0, round_up};
  assign exp_r    = exp_n + {10'd0, mant_r[24]};    // rounding carry
  assign frac23   = mant_r[24] ? mant_r[23:1] : mant_r[22:0];

  assign sum_zero  = ~|s1_sum;
  assign underflow = exp_n[10] | (exp_n == 11'd0);  // below smallest normal
  assign overflow  = ~underflow & (exp_r >= {1'b0, INF_EXP});

  always_comb begin
    res_o.inv     = 1'b0;
    res_o.ovf     = 1'b0;
    res_o.inexact = 1'b0;
    if (s1_spec) begin
      res_o.word = s1_spec_word;
      res_o.inv  = s1_inv;
    end else if (sum_zero) begin
      res_o.word = {s1_sign, 31'd0};
    end else if (underflow) begin
      res_o.word    = {s1_sign, 31'd0};  // flush to zero
      res_o.inexact = 1'b1;
    end else if (overflow) begin
      res_o.word    = {s1_sign, INF_EXP[7:0], 23'd0};
      res_o.ovf     = 1'b1;
      res_o.inexact = 1'b1;
    end else begin
      res_o.word    = {s1_sign, exp_r[7:0], frac23};
      res_o.inexact = rnd_bit | sticky;
    end
  end

  assign ready_o = s1_valid;

  // fcmp magnitude flags put the larger operand first, so the subtract never wraps
  a_mag_order : assert property (@(posedge clk) disable iff (!rst_n_i)
                                 start_i |-> {opl.exp10, opl.fract24} >= {ops.exp10, ops.fract24})
    else $error("addsub operands not ordered by magnitude");

endmodule

//--- verilog/pfpu32_top.sv
// fixed two register latency for all ops, no back-pressure; results are one-cycle pulses on ready_o
`timescale 1ns/100ps

module pfpu32_top
  import or1k_fpu_op_pkg::*;
  import pfpu32_num_pkg::*;
(
  input  logic          clk,
  input  logic          rst_n_i,
  input  logic          start_i,
  input  fpu_op_t       op_i,
  input  logic [31:0]   opa_i,
  input  logic [31:0]   opb_i,
  output logic          ready_o,
  output logic          cmp_valid_o,   // result is a compare
  output fp_cmp_res_t   cmp_res_o,
  output fp_arith_res_t arith_res_o
);

  fp_operand_t   opnd_a, opnd_b;
  logic          agtb, aeqb;
  fp_cmp_res_t   cmp_res;
  logic          cmp_ready;
  fp_arith_res_t arith_res;
  logic          arith_ready;

  pfpu32_unpack u_unpack_a (.word_i(opa_i), .opnd_o(opnd_a));
  pfpu32_unpack u_unpack_b (.word_i(opb_i), .opnd_o(opnd_b));

  pfpu32_fcmp u_fcmp (
    .clk              (clk),
    .fpu_op_is_comp_i (op_i.is_comp),
    .op_i             (op_i),
    .opa_i            (opnd_a),
    .opb_i            (opnd_b),
    .addsub_agtb_o    (agtb),
    .addsub_aeqb_o    (aeqb),
    .res_o            (cmp_res),
    .ready_o          (cmp_ready)
  );

  pfpu32_addsub u_addsub (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .start_i (start_i & ~op_i.is_comp),  // arithmetic only
    .op_i    (op_i),
    .opa_i   (opnd_a),
    .opb_i   (opnd_b),
    .agtb_i  (agtb),
    .aeqb_i  (aeqb),
    .res_o   (arith_res),
    .ready_o (arith_ready)
  );

  ////////////////////////////////////////
  // stage 1, compare result and opcode
  ////////////////////////////////////////

  logic        s1_valid;
  fpu_op_t     s1_op;
  fp_cmp_res_t s1_cmp_res;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= start_i;
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) s1_op <= op_i;
    if (start_i & cmp_ready) s1_cmp_res <= cmp_res;  // fcmp is combinational
  end

  ////////////////////////////////////////
  // stage 2, output register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_o     <= 1'b0;
      cmp_valid_o <= 1'b0;
      cmp_res_o   <= '0;
      arith_res_o <= '0;
    end else begin
      ready_o     <= s1_valid;
      cmp_valid_o <= s1_valid & s1_op.is_comp;
      if (s1_valid & s1_op.is_comp) cmp_res_o <= s1_cmp_res;
      if (arith_ready) arith_res_o <= arith_res;  // holds until next add/sub
    end
  end

  // opcode decode never mixes compare and subtract
  a_op_legal : assert property (@(posedge clk) disable iff (!rst_n_i)
                                start_i |-> !(op_i.is_comp && op_i.is_sub))
    else $error("compare opcode with subtract bit");

endmodule

//--- test/tb_pfpu32.sv
// assumes a fixed 2 cycle latency; model flushes denormals to signed zero and gives one canonical NaN
`timescale 1ns/100ps

module tb_pfpu32
  import or1k_fpu_op_pkg::*;
  import pfpu32_num_pkg::*;
();

  localparam int SEED      = 71740;
  localparam int N_ADD     = 300;
  localparam int N_SPEC    = 200;
  localparam int N_CMP     = 300;
  localparam int N_NAN_CMP = 100;
  localparam int N_B2B     = 150;  // each op followed by up to 3 idle cycles
  localparam int CYCLE_LIMIT = 3 + N_ADD + N_SPEC + N_CMP + N_NAN_CMP + 4 * N_B2B + 3 + 20;

  // what the DUT should return for one strobe
  typedef struct packed {
    logic          is_comp;
    fp_cmp_res_t   cmp;
    fp_arith_res_t arith;
  } expect_t;

  logic          clk;
  logic          rst_n_i;
  logic          start_i;
  fpu_op_t       op_i;
  logic [31:0]   opa_i;
  logic [31:0]   opb_i;
  logic          ready_o;
  logic          cmp_valid_o;
  fp_cmp_res_t   cmp_res_o;
  fp_arith_res_t arith_res_o;

  expect_t    exp_q[$];
  logic [1:0] strobe_hist;     // [1] is the strobe two cycles back
  int         cycle_cnt = 0;

  pfpu32_top dut (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .start_i     (start_i),
    .op_i        (op_i),
    .opa_i       (opa_i),
    .opb_i       (opb_i),
    .ready_o     (ready_o),
    .cmp_valid_o (cmp_valid_o),
    .cmp_res_o   (cmp_res_o),
    .arith_res_o (arith_res_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout, run went past %0d cycles", CYCLE_LIMIT);
      abort_run();
    end
  end

  ////////////////////////////////////////
  // failure reporting
  ////////////////////////////////////////

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("ERR %0t %s got=%h expected=%h", $time, name, got, want);
      abort_run();
    end
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic logic is_nan(input logic [31:0] w);
    return (w[30:23] == 8'hFF) && (w[22:0] != 23'd0);
  endfunction

  function automatic logic is_snan(input logic [31:0] w);
    return is_nan(w) && !w[22];  // quiet bit clear
  endfunction

  function automatic logic is_inf(input logic [31:0] w);
    return (w[30:23] == 8'hFF) && (w[22:0] == 23'd0);
  endfunction

  // single to double, denormal flushed, NaN never passed in
  function automatic real word_to_real(input logic [31:0] w);
    logic [10:0] e;
    e = {3'b000, w[30:23]} + 11'd896;  // rebias 127 -> 1023
    if (w[30:23] == 8'h00) return $bitstoreal({w[31], 63'd0});
    if (w[30:23] == 8'hFF) return $bitstoreal({w[31], 11'h7FF, 52'd0});
    return $bitstoreal({w[31], e, w[22:0], 29'd0});
  endfunction

  // nearest even, double has enough bits that double rounding is harmless
  function automatic logic [31:0] round_to_single(input real s, output logic ovf,
                                                  output logic lost);
    logic [63:0] d;
    logic [24:0] mant_r;
    logic        rbit;
    logic        sticky;
    int          eb;
    d      = $realtobits(s);
    rbit   = d[28];
    sticky = |d[27:0];
    eb     = int'(d[62:52]) - 896;
    ovf    = 1'b0;
    lost   = rbit | sticky;
    if (eb <= 0) begin
      lost = 1'b1;  // below smallest normal, flush
      return {d[63], 31'd0};
    end
    mant_r = {2'b01, d[51:29]} + 25'(rbit & (sticky | d[29]));
    if (mant_r[24]) eb = eb + 1;  // mantissa wrapped, fraction is zero
    if (eb >= 255) begin
      ovf  = 1'b1;
      lost = 1'b1;
      return {d[63], 8'hFF, 23'd0};
    end
    return {d[63], 8'(eb), mant_r[24] ? 23'd0 : mant_r[22:0]};
  endfunction

  function automatic fp_arith_res_t model_add(input logic [31:0] a, input logic [31:0] b,
                                              input logic is_sub);
    fp_arith_res_t r;
    logic          sb;
    logic          ovf;
    logic          lost;
    real           ad, bd, s, bb, err;
    r  = '0;
    sb = b[31] ^ is_sub;  // effective sign of b
    if (is_nan(a) || is_nan(b)) begin
      r.word = QNAN_CANON;
      r.inv  = is_snan(a) | is_snan(b);
    end else if (is_inf(a) && is_inf(b) && (a[31] != sb)) begin
      r.word = QNAN_CANON;  // inf - inf
      r.inv  = 1'b1;
    end else if (is_inf(a)) begin
      r.word = {a[31], 8'hFF, 23'd0};
    end else if (is_inf(b)) begin
      r.word = {sb, 8'hFF, 23'd0};
    end else begin
      ad = word_to_real(a);
      bd = is_sub ? -word_to_real(b) : word_to_real(b);
      s  = ad + bd;
      if (ad == 0.0 && bd == 0.0) begin
        r.word = {a[31] & sb, 31'd0};  // -0 only from -0 + -0
      end else if (s == 0.0) begin
        r.word = 32'd0;  // exact cancellation
      end else begin
        bb        = s - ad;
        err       = (ad - (s - bb)) + (bd - bb);  // two-sum error of the double add
        r.word    = round_to_single(s, ovf, lost);
        r.ovf     = ovf;
        r.inexact = lost | (err != 0.0);
      end
    end
    return r;
  endfunction

  function automatic fp_cmp_res_t model_cmp(input logic [31:0] a, input logic [31:0] b,
                                            input fpu_op_t op);
    fp_cmp_res_t r;
    logic        anan;
    logic        eqne;
    real         ad, bd;
    anan  = is_nan(a) | is_nan(b);
    eqne  = (op.generic_cmp == SFEQ) || (op.generic_cmp == SFNE);
    r.inv = (eqne & (is_snan(a) | is_snan(b))) | (~eqne & anan & ~op.unordered);
    r.inf = is_inf(a) | is_inf(b);
    if (anan) begin
      r.cmp_flag = op.unordered | (op.generic_cmp == SFNE);  // NaN equals nothing
    end else begin
      ad = word_to_real(a);  // real compare gives -0 == +0
      bd = word_to_real(b);
      case (op.generic_cmp)
        SFEQ:    r.cmp_flag = (ad == bd);
        SFNE:    r.cmp_flag = (ad != bd);
        SFGT:    r.cmp_flag = (ad > bd);
        SFGE:    r.cmp_flag = (ad >= bd);
        SFLT:    r.cmp_flag = (ad < bd);
        SFLE:    r.cmp_flag = (ad <= bd);
        default: r.cmp_flag = 1'b0;
      endcase
    end
    return r;
  endfunction

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  function automatic fpu_op_t add_op(input logic sub);
    fpu_op_t op;
    op        = '0;
    op.is_sub = sub;
    return op;
  endfunction

  function automatic fpu_op_t rand_cmp_op();
    fpu_op_t op;
    op             = '0;
    op.is_comp     = 1'b1;
    op.unordered   = 1'($urandom);
    op.generic_cmp = fpu_generic_cmp_e'(3'($urandom % 6));  // codes 0..5 only
    return op;
  endfunction

  function automatic logic [31:0] rand_normal(input int lo, input int hi);
    logic [7:0] e;
    e = 8'(lo + int'($urandom % (hi - lo + 1)));
    return {1'($urandom), e, 23'($urandom)};
  endfunction

  function automatic logic [31:0] rand_nan(input logic quiet);
    logic [21:0] low;
    low = 22'($urandom);
    if (!quiet && low == 22'd0) low = 22'd1;  // keep sNaN off inf
    return {1'($urandom), 8'hFF, quiet, low};
  endfunction

  function automatic logic [31:0] pick_special();
    case ($urandom % 9)
      0:       return {1'($urandom), 31'd0};  // signed zero
      1:       return {1'($urandom), 8'hFF, 23'd0};
      2:       return rand_nan(1'b1);
      3:       return rand_nan(1'b0);
      4:       return {1'($urandom), 8'h00, 23'($urandom)};  // denormal
      5, 6:    return {1'($urandom), 8'(253 + $urandom % 2), 23'($urandom)};  // near max
      default: return rand_normal(60, 190);
    endcase
  endfunction

  task automatic make_cmp_pair(output logic [31:0] a, output logic [31:0] b);
    a = rand_normal(60, 190);
    case ($urandom % 6)
      0:       b = rand_normal(60, 190);
      1:       b = a;
      2:       b = a ^ 32'h8000_0000;               // opposite sign
      3:       b = {a[31:23], 23'($urandom)};       // same exponent
      4: begin
        a = {1'($urandom), 31'd0};                  // +0 / -0 pairs
        b = {1'($urandom), 31'd0};
      end
      default: b = {1'($urandom), 8'hFF, 23'd0};
    endcase
  endtask

  task automatic check_outputs();
    expect_t e;
    check_value("ready_o", ready_o, strobe_hist[1]);
    if (ready_o) begin
      e = exp_q.pop_front();
      check_value("cmp_valid_o", cmp_valid_o, e.is_comp);
      if (e.is_comp) begin
        check_value("cmp_res_o.cmp_flag", cmp_res_o.cmp_flag, e.cmp.cmp_flag);
        check_value("cmp_res_o.inv", cmp_res_o.inv, e.cmp.inv);
        check_value("cmp_res_o.inf", cmp_res_o.inf, e.cmp.inf);
      end else begin
        check_value("arith_res_o.word", arith_res_o.word, e.arith.word);
        check_value("arith_res_o.inv", arith_res_o.inv, e.arith.inv);
        check_value("arith_res_o.ovf", arith_res_o.ovf, e.arith.ovf);
        check_value("arith_res_o.inexact", arith_res_o.inexact, e.arith.inexact);
      end
    end else begin
      check_value("cmp_valid_o", cmp_valid_o, 32'd0);  // idle cycle
    end
  endtask

  // one falling edge: check the outputs, then drive the next inputs
  task automatic step(input logic start, input fpu_op_t op, input logic [31:0] a,
                      input logic [31:0] b);
    expect_t e;
    @(negedge clk);
    check_outputs();
    start_i = start;
    op_i    = op;
    opa_i   = a;
    opb_i   = b;
    if (start) begin
      e.is_comp = op.is_comp;
      e.cmp     = model_cmp(a, b, op);
      e.arith   = model_add(a, b, op.is_sub);
      exp_q.push_back(e);
    end
    strobe_hist = {strobe_hist[0], start};
  endtask

  task automatic idle_cycle();
    step(1'b0, '0, 32'd0, 32'd0);
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0] a, b;
    void'($urandom(SEED));
    rst_n_i     = 1'b0;
    start_i     = 1'b0;
    op_i        = '0;
    opa_i       = 32'd0;
    opb_i       = 32'd0;
    strobe_hist = 2'b00;  // ready must stay low out of reset
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n_i = 1'b1;

    repeat (N_ADD) begin
      a = rand_normal(60, 190);
      b = rand_normal(60, 190);
      if ($urandom % 4 == 0) b[30:23] = a[30:23];  // cancellation cases
      step(1'b1, add_op(1'($urandom)), a, b);
    end
    repeat (N_SPEC) step(1'b1, add_op(1'($urandom)), pick_special(), pick_special());
    repeat (N_CMP) begin
      make_cmp_pair(a, b);
      step(1'b1, rand_cmp_op(), a, b);
    end
    repeat (N_NAN_CMP) begin
      a = rand_nan(1'($urandom));
      b = pick_special();
      if ($urandom % 2) step(1'b1, rand_cmp_op(), a, b);
      else              step(1'b1, rand_cmp_op(), b, a);
    end
    // mixed ops with random idle gaps
    repeat (N_B2B) begin
      a = pick_special();
      b = pick_special();
      if ($urandom % 2) step(1'b1, rand_cmp_op(), a, b);
      else              step(1'b1, add_op(1'($urandom)), a, b);
      repeat ($urandom % 4) idle_cycle();
    end
    repeat (3) idle_cycle();  // drain the pipe

    if (exp_q.size() == 0) begin
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("%0d results never arrived", exp_q.size());
      abort_run();
    end
  end

endmodule

//--- verilog.f
verilog/or1k_fpu_op_pkg.sv
verilog/pfpu32_num_pkg.sv
verilog/pfpu32_unpack.sv
verilog/pfpu32_fcmp.sv
verilog/pfpu32_addsub.sv
verilog/pfpu32_top.sv
test/tb_pfpu32.sv
